// File: uart_cmd.f
src/uart_cmd_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_ctrl.sv
src/uart_cmd_top.sv
testbench/uart_cmd_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_cmd_tb -f uart_cmd.f -o uart_cmd_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/uart_cmd_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

// File: testbench/uart_cmd_vectors.txt
# columns: name op cmd reply corrupt exp_err
# cmd and reply in hex; wr_busy offers ~cmd while the write runs
wr_basic      wr      8155 00 0 0
wr_addr_max   wr      ffa5 00 0 0
wr_zero_data  wr      8000 00 0 0
rd_basic      rd      0500 a5 0 0
rd_zero       rd      7f00 00 0 0
rd_all_ones   rd      1234 ff 0 0
wr_busy       wr_busy 9a3c 00 0 0
wr_after_busy wr      c366 00 0 0
rd_bad_par    rd      2200 3c 1 1
rd_after_bad  rd      2300 81 0 0
rd_bad_par2   rd      4400 7e 1 1
wr_final      wr      80ff 00 0 0

// File: testbench/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  localparam int start_limit = 40 * clks_per_bit;  // cycles allowed before a start bit
  localparam int reply_limit = 2 * clks_per_bit;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [cmd_width-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic                  read_rdy;
  logic [data_width-1:0] read_data;
  logic                  read_err;
  integer                seed;
  string                 test_name;
  int                    test_errs;
  int                    passed;
  int                    failed;
  bit                    timed_out;

  uart_cmd_top uart_cmd_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
    else begin
      $display("Mismatch %0s %0s: expected %0h, actual %0h", test_name, what, expected,
               actual);
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%0s: no %0s arrived before the timeout, test abandoned", test_name, what);
    test_errs++;
    timed_out = 1'b1;
  endtask

  task automatic wait_high(input bit for_read, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while ((for_read ? read_rdy : cmd_rdy) !== 1'b1 && n < limit);
    if ((for_read ? read_rdy : cmd_rdy) !== 1'b1) begin
      report_timeout(for_read ? "read_rdy pulse" : "cmd_rdy");
    end
  endtask

  // samples tx mid-bit and counts idle cycles up to the start bit
  task automatic decode_frame(output logic [data_width-1:0] data, output logic par,
                              output logic stop, output int idle);
    idle = 0;
    do begin
      @(negedge clk);
      idle++;
    end while (tx !== 1'b0 && idle < start_limit);
    if (tx !== 1'b0) begin
      report_timeout("start bit on tx");
      return;
    end
    repeat (half_bit) @(negedge clk);
    for (int i = 0; i < data_width; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    par = tx;
    repeat (clks_per_bit) @(negedge clk);
    stop = tx;
  endtask

  // remote device answering a read
  task automatic drive_reply(input logic [data_width-1:0] data, input logic corrupt);
    int         delay_bits;
    logic [9:0] bits;
    delay_bits = 1 + ($unsigned($random(seed)) % 20);
    bits = {(^data) ^ corrupt, data, 1'b0};  // parity, lsb-first data, start
    repeat (delay_bits * clks_per_bit) @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      #1 rx = bits[i];
      repeat (clks_per_bit) @(posedge clk);
    end
    #1 rx = 1'b1;  // stop bit, then the line idles
  endtask

  task automatic run_vector(input logic [63:0] op, input logic [cmd_width-1:0] cmd,
                            input logic [7:0] reply, input logic corrupt, input logic exp_err);
    logic [data_width-1:0] data;
    logic                  par;
    logic                  stop;
    int                    idle;
    bit                    is_write;
    bit                    extra;
    is_write = (op != "rd");
    extra = 1'b0;
    wait_high(1'b0, start_limit);
    if (timed_out) return;
    @(posedge clk);
    #1;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);  // accepting edge
    #1;
    if (op == "wr_busy") cmd_in = ~cmd;  // must be dropped
    else cmd_vld = 1'b0;
    decode_frame(data, par, stop, idle);
    if (timed_out) return;
    check_value("header byte", {is_write, cmd[cmd_write_bit-1:data_width]}, data);
    check_value("header parity", ^data, par);
    check_value("header stop bit", 1'b1, stop);
    if (!is_write) begin
      drive_reply(reply, corrupt);
      wait_high(1'b1, reply_limit);
      if (timed_out) return;
      check_value("read_data", reply, read_data);
      check_value("read_err", exp_err, read_err);
      check_value("cmd_rdy with read_rdy", 1'b1, cmd_rdy);
      @(negedge clk);
      check_value("read_rdy after pulse", 1'b0, read_rdy);
      return;
    end
    decode_frame(data, par, stop, idle);
    if (timed_out) return;
    @(posedge clk);
    #1 cmd_vld = 1'b0;
    check_value("data byte", cmd[7:0], data);
    check_value("data parity", ^data, par);
    check_value("data stop bit", 1'b1, stop);
    assert (idle - half_bit >= frame_gap_bits * clks_per_bit)
    else begin
      $display("%0s: idle gap of %0d cycles is shorter than %0d bit times", test_name,
               idle - half_bit, frame_gap_bits);
      test_errs++;
    end
    wait_high(1'b0, start_limit);
    if (timed_out) return;
    repeat (3 * clks_per_bit) begin
      @(negedge clk);
      if (tx !== 1'b1) extra = 1'b1;
    end
    assert (!extra)
    else begin
      $display("%0s: tx sent another frame after the write completed", test_name);
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      passed++;
      $display("test %0s ok", test_name);
    end else begin
      failed++;
      $display("test %0s failed with %0d errors", test_name, test_errs);
    end
  endtask

  initial begin
    integer                fd;
    int                    n;
    logic [8*80-1:0]       line;
    logic [8*16-1:0]       name_r;
    logic [8*8-1:0]        op_r;
    logic [cmd_width-1:0]  cmd_v;
    logic [data_width-1:0] reply_v;
    int                    corrupt_v;
    int                    err_v;
    seed      = 32'h3c57;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    test_name = "reset";
    test_errs = 0;
    repeat (5) begin
      @(negedge clk);
      check_value("tx", 1'b1, tx);
      check_value("cmd_rdy", 1'b1, cmd_rdy);
      check_value("read_rdy", 1'b0, read_rdy);
    end
    close_test();
    fd = $fopen("testbench/uart_cmd_vectors.txt", "r");
    if (fd == 0) begin
      $display("vector file testbench/uart_cmd_vectors.txt could not be opened");
      failed++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %s %h %h %d %d", name_r, op_r, cmd_v, reply_v, corrupt_v, err_v);
        if (n == 6 && (op_r == "wr" || op_r == "wr_busy" || op_r == "rd")) begin
          test_name = string'(name_r);
          test_errs = 0;
          run_vector(op_r, cmd_v, reply_v, corrupt_v[0], err_v[0]);
          close_test();
        end
      end
      $fclose(fd);
    end
    $display("tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0 && passed > 1) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [cmd_width-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  rx,
  output logic                  tx,
  output logic                  read_rdy,
  output logic [data_width-1:0] read_data,
  output logic                  read_err
);

  logic                  tx_start;
  logic [data_width-1:0] tx_byte;
  logic                  tx_busy;
  logic                  tx_done;
  logic                  rx_valid;
  logic [data_width-1:0] rx_byte;
  logic                  rx_err;

  uart_cmd_ctrl uart_cmd_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // receiver is always listening, ctrl picks the reply
  uart_rx uart_rx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .rx_err   (rx_err)
  );

endmodule

// File: src/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [cmd_width-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output logic [data_width-1:0] tx_byte,
  input  logic                  tx_busy,
  input  logic                  tx_done,
  input  logic                  rx_valid,
  input  logic [data_width-1:0] rx_byte,
  input  logic                  rx_err,
  output logic                  read_rdy,
  output logic [data_width-1:0] read_data,
  output logic                  read_err
);

  ctrl_state_e              state;
  logic [cmd_width-1:0]     cmd_reg;
  logic                     launched;  // frame of the current state handed to tx
  logic [gap_cnt_width-1:0] gap_cnt;

  assign cmd_rdy  = (state == st_idle);
  assign tx_start = !launched && (state == st_send_head || state == st_send_data);

  // header carries the r/w flag and address, data frame the low byte
  assign tx_byte = (state == st_send_data) ? cmd_reg[data_width-1:0] :
                                             cmd_reg[cmd_width-1 -: data_width];

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_reg <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      launched <= 1'b0;
      gap_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      if (tx_done) begin
        launched <= 1'b0;
      end else if (tx_start) begin
        launched <= 1'b1;
      end

      case (state)
        st_idle: begin
          if (cmd_vld) begin
            state <= st_send_head;
          end
        end
        st_send_head: begin
          if (tx_done) begin
            if (cmd_reg[cmd_write_bit]) begin
              state   <= st_gap;
              gap_cnt <= '0;
            end else begin
              state <= st_wait_reply;
            end
          end
        end
        st_gap: begin
          if (gap_cnt == gap_cnt_width'(gap_cycles - 1)) begin
            state <= st_send_data;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        st_send_data: begin
          if (tx_done) begin
            state <= st_idle;
          end
        end
        st_wait_reply: begin
          if (rx_valid) begin
            state    <= st_idle;
            read_rdy <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // reply payload, held until the next read
  always_ff @(posedge clk) begin
    if (state == st_wait_reply && rx_valid) begin
      read_data <= rx_byte;
      read_err  <= rx_err;
    end
  end

  a_start_idle : assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("uart_cmd_ctrl: tx_start while transmitter busy");

  a_read_rdy_src : assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> (state == st_idle) && ($past(state) == st_wait_reply))
    else $error("uart_cmd_ctrl: read_rdy outside reply completion");

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  output logic                  rx_valid,
  output logic [data_width-1:0] rx_byte,
  output logic                  rx_err
);

  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_prev;
  logic                       active;
  logic [cycle_cnt_width-1:0] cycle_cnt;
  logic [3:0]                 bit_idx;   // 0 start, then data, parity, stop, tail
  logic [data_width-1:0]      data_sr;
  logic                       par_bit;
  logic                       stop_bit;
  logic                       tick;

  // start check and tail wait half a bit, the rest a full bit
  always_comb begin
    if (bit_idx == 4'd0) begin
      tick = (cycle_cnt == cycle_cnt_width'(half_bit - 1));
    end else if (bit_idx == 4'(data_width + 3)) begin
      tick = (cycle_cnt == cycle_cnt_width'(half_bit - 4));  // short, keeps next edge
    end else begin
      tick = (cycle_cnt == cycle_cnt_width'(clks_per_bit - 1));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_prev   <= 1'b1;
      active    <= 1'b0;
      cycle_cnt <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_prev  <= rx_sync;
      rx_valid <= 1'b0;
      if (!active) begin
        if (rx_prev && !rx_sync) begin  // falling edge
          active    <= 1'b1;
          cycle_cnt <= '0;
          bit_idx   <= '0;
        end
      end else if (tick) begin
        cycle_cnt <= '0;
        bit_idx   <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_sync) begin
          active <= 1'b0;  // glitch
        end else if (bit_idx == 4'(data_width + 3)) begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end
      end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
    end
  end

  // bit sampling and result registers
  always_ff @(posedge clk) begin
    if (active && tick) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'(data_width)) begin
        data_sr <= {rx_sync, data_sr[data_width-1:1]};  // lsb first
      end else if (bit_idx == 4'(data_width + 1)) begin
        par_bit <= rx_sync;
      end else if (bit_idx == 4'(data_width + 2)) begin
        stop_bit <= rx_sync;
      end else if (bit_idx == 4'(data_width + 3)) begin
        rx_byte <= data_sr;
        rx_err  <= (^data_sr ^ par_bit) | ~stop_bit;
      end
    end
  end

  a_valid_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid)
    else $error("uart_rx: rx_valid held longer than one cycle");

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  logic [data_width-1:0] tx_byte,
  output logic                  tx,
  output logic                  tx_busy,
  output logic                  tx_done
);

  logic [data_width+1:0]      frame_sr;  // data, parity, stop
  logic [cycle_cnt_width-1:0] cycle_cnt;
  logic [3:0]                 bit_cnt;   // 0 = start bit
  logic                       last_cycle;
  logic                       bit_end;

  // stop bit ends one cycle early so done lands exactly 11 bit times after start
  assign last_cycle = (bit_cnt == 4'(data_width + 2)) &&
                      (cycle_cnt == cycle_cnt_width'(clks_per_bit - 2));
  assign bit_end    = (cycle_cnt == cycle_cnt_width'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx        <= 1'b1;
      tx_busy   <= 1'b0;
      tx_done   <= 1'b0;
      cycle_cnt <= '0;
      bit_cnt   <= '0;
    end else begin
      tx_done <= 1'b0;
      if (!tx_busy && tx_start) begin
        tx        <= 1'b0;  // start bit
        tx_busy   <= 1'b1;
        cycle_cnt <= '0;
        bit_cnt   <= '0;
      end else if (tx_busy) begin
        if (last_cycle) begin
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end else if (bit_end) begin
          cycle_cnt <= '0;
          bit_cnt   <= bit_cnt + 1'b1;
          tx        <= frame_sr[0];
        end else begin
          cycle_cnt <= cycle_cnt + 1'b1;
        end
      end
    end
  end

  // payload shifter
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      frame_sr <= {1'b1, ^tx_byte, tx_byte};  // even parity
    end else if (tx_busy && bit_end) begin
      frame_sr <= {1'b1, frame_sr[data_width+1:1]};
    end
  end

  // line must idle high between frames
  a_idle_high : assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx)
    else $error("uart_tx: tx low while idle");

endmodule

// File: src/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // serial timing
  localparam int clks_per_bit    = 434;  // 115200 baud at 50 MHz
  localparam int half_bit        = clks_per_bit / 2;
  localparam int cycle_cnt_width = $clog2(clks_per_bit);

  // command word layout
  localparam int cmd_width     = 16;
  localparam int data_width    = 8;
  localparam int cmd_write_bit = 15;  // 1 = write, 0 = read

  // idle time between the header and data frames of a write
  localparam int frame_gap_bits = 2;
  localparam int gap_cycles     = frame_gap_bits * clks_per_bit;
  localparam int gap_cnt_width  = $clog2(gap_cycles);

  typedef enum logic [2:0] {
    st_idle,
    st_send_head,
    st_gap,
    st_send_data,
    st_wait_reply
  } ctrl_state_e;

endpackage
